/* Makefile */
# Verilator build and run for the image store testbench

VERILATOR ?= verilator
TOP       ?= tb_img_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard tb/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
+incdir+tb
hdl/img_pkg.sv
hdl/op_ctrl.sv
hdl/display_streamer.sv
hdl/image_mem.sv
hdl/img_core.sv
tb/tb_img_core.sv

/* hdl/display_streamer.sv */
`default_nettype none

module display_streamer #(
    parameter int BANK_COUNT = 4
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_start,
    input  wire img_pkg::win_pos_t i_win,
    input  wire img_pkg::pixel_t   i_rd_data,
    output img_pkg::bank_rd_t      o_rd,
    output img_pkg::pix_out_t      o_pix,
    output logic                   o_done
);
    import img_pkg::*;

    logic      active;      // issuing reads
    logic      drain;       // last read issued, waiting for pipeline
    logic [1:0] pos;        // 0:(0,0) 1:(1,0) 2:(0,1) 3:(1,1)
    chan_t     ch;
    logic      rd_vld;      // stage 1, memory data valid
    logic      out_vld;     // stage 2, output valid
    out_data_t out_data;
    coord_t    rd_x, rd_y;
    bank_loc_t rd_loc;

    // -------------------------------------------------
    // window walk
    // -------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active <= 1'b0;
            drain  <= 1'b0;
            pos    <= '0;
            ch     <= '0;
        end else if (i_start) begin
            active <= 1'b1;
            pos    <= '0;
            ch     <= '0;
        end else if (active) begin
            pos <= pos + 2'd1;
            if (pos == 2'd3) begin
                if (ch == depth_last(i_win.depth)) begin
                    active <= 1'b0;   // all channels issued
                    drain  <= 1'b1;
                end else begin
                    ch <= ch + chan_t'(1);
                end
            end
        end else if (o_done) begin
            drain <= 1'b0;
        end
    end

    assign rd_x   = i_win.x + coord_t'(pos[0]);
    assign rd_y   = i_win.y + coord_t'(pos[1]);
    assign rd_loc = xyc_to_bank(rd_x, rd_y, ch, BANK_COUNT);
    assign o_rd   = '{en: active, bank: rd_loc.bank, off: rd_loc.off};

    // -------------------------------------------------
    // two-stage valid pipe, read data lands in stage 1
    // -------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_vld  <= 1'b0;
            out_vld <= 1'b0;
        end else begin
            rd_vld  <= active;
            out_vld <= rd_vld;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_vld) out_data <= out_data_t'({6'd0, i_rd_data});   // zero-extend
    end

    assign o_pix  = '{valid: out_vld, data: out_data};
    assign o_done = drain && !rd_vld && !out_vld;   // nothing left in flight

endmodule

`default_nettype wire

/* hdl/image_mem.sv */
`default_nettype none

module image_mem #(
    parameter int BANK_COUNT = 4
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire img_pkg::bank_wr_t i_wr,
    input  wire img_pkg::bank_rd_t i_rd,
    output img_pkg::pixel_t        o_rd_data
);
    import img_pkg::*;

    localparam int BANK_DEPTH = IMG_PIX / BANK_COUNT;
    localparam int OFF_W      = $clog2(BANK_DEPTH);
    localparam int BANK_W     = $clog2(BANK_COUNT);

    pixel_t            rd_q [BANK_COUNT];   // per-bank read data
    logic [BANK_W-1:0] sel_r;               // bank picked last cycle

    // -------------------------------------------------
    // one array per bank
    // -------------------------------------------------
    for (genvar g = 0; g < BANK_COUNT; g++) begin : g_bank
        pixel_t mem [BANK_DEPTH];

        always_ff @(posedge i_clk) begin
            if (i_wr.en && i_wr.bank[BANK_W-1:0] == BANK_W'(g)) begin
                mem[i_wr.off[OFF_W-1:0]] <= i_wr.data;
            end
            if (i_rd.en) begin
                rd_q[g] <= mem[i_rd.off[OFF_W-1:0]];   // all banks read same offset
            end
        end
    end

    // bank select follows the data by one cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sel_r <= '0;
        end else if (i_rd.en) begin
            sel_r <= i_rd.bank[BANK_W-1:0];
        end
    end

    assign o_rd_data = rd_q[sel_r];

endmodule

`default_nettype wire

/* hdl/img_core.sv */
`default_nettype none

module img_core #(
    parameter int BANK_COUNT = 4      // 2, 4 or 8
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire img_pkg::op_cmd_t  i_op,
    input  wire img_pkg::pix_in_t  i_pix,
    output logic                   o_op_ready,
    output logic                   o_in_ready,
    output img_pkg::pix_out_t      o_pix
);
    import img_pkg::*;

    // internal links
    bank_wr_t wr;
    bank_rd_t rd;
    win_pos_t win;
    pixel_t   rd_data;
    logic     disp_start;
    logic     disp_done;

    op_ctrl #(.BANK_COUNT(BANK_COUNT)) u_op_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op         (i_op),
        .i_pix        (i_pix),
        .i_disp_done  (disp_done),
        .o_op_ready   (o_op_ready),
        .o_in_ready   (o_in_ready),
        .o_wr         (wr),
        .o_win        (win),
        .o_disp_start (disp_start)
    );

    display_streamer #(.BANK_COUNT(BANK_COUNT)) u_display_streamer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (disp_start),
        .i_win     (win),
        .i_rd_data (rd_data),
        .o_rd      (rd),
        .o_pix     (o_pix),
        .o_done    (disp_done)
    );

    image_mem #(.BANK_COUNT(BANK_COUNT)) u_image_mem (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (wr),
        .i_rd      (rd),
        .o_rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* hdl/img_pkg.sv */
`default_nettype none

package img_pkg;

    // -------------------------------------------------
    // image geometry
    // -------------------------------------------------
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int IMG_CH  = 32;
    localparam int IMG_PIX = IMG_W * IMG_H * IMG_CH;   // 2048
    localparam int ORG_MAX = 6;                        // 2x2 window must fit

    typedef logic [7:0]         pixel_t;
    typedef logic signed [13:0] out_data_t;
    typedef logic [2:0]         coord_t;
    typedef logic [4:0]         chan_t;
    typedef logic [10:0]        pix_idx_t;   // {c, y, x}

    // sized for the widest case: 8 banks or 1024 words per bank
    typedef logic [2:0] bank_t;
    typedef logic [9:0] bank_off_t;

    typedef enum logic [3:0] {
        OP_LOAD    = 4'd0,
        OP_ORG_R   = 4'd1,
        OP_ORG_L   = 4'd2,
        OP_ORG_U   = 4'd3,
        OP_ORG_D   = 4'd4,
        OP_SCALE_D = 4'd5,
        OP_SCALE_U = 4'd6,
        OP_DISPLAY = 4'd7
    } op_mode_t;   // 8..15 undefined, ignored by the core

    typedef enum logic [1:0] {D8 = 2'd0, D16 = 2'd1, D32 = 2'd2} depth_t;

    // -------------------------------------------------
    // port bundles
    // -------------------------------------------------
    typedef struct packed {logic valid; op_mode_t mode;} op_cmd_t;
    typedef struct packed {logic valid; pixel_t data;} pix_in_t;
    typedef struct packed {logic valid; out_data_t data;} pix_out_t;
    typedef struct packed {coord_t x; coord_t y; depth_t depth;} win_pos_t;
    typedef struct packed {bank_t bank; bank_off_t off;} bank_loc_t;
    typedef struct packed {logic en; bank_t bank; bank_off_t off; pixel_t data;} bank_wr_t;
    typedef struct packed {logic en; bank_t bank; bank_off_t off;} bank_rd_t;

    function automatic chan_t depth_last(depth_t d);
        case (d)
            D8:      return chan_t'(7);
            D16:     return chan_t'(15);
            default: return chan_t'(31);
        endcase
    endfunction

    // low channel bits pick the bank, the rest of the channel sits above y,x
    function automatic bank_loc_t raster_to_bank(pix_idx_t idx, int unsigned bank_count);
        chan_t     c;
        bank_loc_t loc;
        c        = idx[10:6];
        loc.bank = bank_t'(c % bank_count);
        loc.off  = bank_off_t'((c / bank_count) * (IMG_W * IMG_H) + idx[5:0]);
        return loc;
    endfunction

    function automatic bank_loc_t xyc_to_bank(coord_t x, coord_t y, chan_t c,
                                              int unsigned bank_count);
        return raster_to_bank({c, y, x}, bank_count);   // same packing as raster order
    endfunction

endpackage

`default_nettype wire

/* hdl/op_ctrl.sv */
`default_nettype none

module op_ctrl #(
    parameter int BANK_COUNT = 4
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire img_pkg::op_cmd_t  i_op,
    input  wire img_pkg::pix_in_t  i_pix,
    input  wire logic              i_disp_done,
    output logic                   o_op_ready,
    output logic                   o_in_ready,
    output img_pkg::bank_wr_t      o_wr,
    output img_pkg::win_pos_t      o_win,
    output logic                   o_disp_start
);
    import img_pkg::*;

    typedef enum logic [2:0] {
        S_RESET,
        S_START,
        S_READY,    // one-cycle op_ready pulse
        S_WAIT,
        S_LOAD,
        S_EXEC,     // shift / scale, single cycle
        S_DISP      // streamer busy
    } state_t;

    state_t    state, state_nxt;
    op_cmd_t   op_r;        // registered host op
    pix_in_t   pix_r;       // registered host pixel
    op_mode_t  cur_op;      // op being executed
    pix_idx_t  load_cnt;    // raster index of next pixel
    coord_t    org_x, org_y;
    depth_t    depth;
    bank_loc_t wr_loc;
    logic      last_pix;

    // -------------------------------------------------
    // input register
    // -------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            op_r  <= '0;
            pix_r <= '0;
        end else begin
            op_r  <= i_op;
            pix_r <= i_pix;
        end
    end

    assign last_pix = (load_cnt == pix_idx_t'(IMG_PIX - 1));

    // -------------------------------------------------
    // main FSM
    // -------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            S_RESET: state_nxt = S_START;
            S_START: state_nxt = S_READY;
            S_READY: state_nxt = S_WAIT;
            S_WAIT: begin
                if (op_r.valid) begin
                    case (op_r.mode)
                        OP_LOAD:    state_nxt = S_LOAD;
                        OP_ORG_R, OP_ORG_L, OP_ORG_U, OP_ORG_D,
                        OP_SCALE_D, OP_SCALE_U: state_nxt = S_EXEC;
                        OP_DISPLAY: state_nxt = S_DISP;
                        default:    state_nxt = S_WAIT;   // undefined code, keep waiting
                    endcase
                end
            end
            S_LOAD:  if (pix_r.valid && last_pix) state_nxt = S_READY;
            S_EXEC:  state_nxt = S_READY;
            S_DISP:  if (i_disp_done) state_nxt = S_READY;
            default: state_nxt = S_RESET;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= S_RESET;
            cur_op <= OP_LOAD;
        end else begin
            state <= state_nxt;
            if (state == S_WAIT && op_r.valid) cur_op <= op_r.mode;
        end
    end

    // -------------------------------------------------
    // load counter, origin and depth
    // -------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_cnt <= '0;
            org_x    <= '0;
            org_y    <= '0;
            depth    <= D32;
        end else begin
            if (state == S_LOAD && pix_r.valid) begin
                load_cnt <= last_pix ? '0 : load_cnt + pix_idx_t'(1);   // gaps hold
            end
            if (state == S_EXEC) begin
                case (cur_op)
                    OP_ORG_R: if (org_x < coord_t'(ORG_MAX)) org_x <= org_x + coord_t'(1);
                    OP_ORG_L: if (org_x != '0) org_x <= org_x - coord_t'(1);
                    OP_ORG_U: if (org_y != '0) org_y <= org_y - coord_t'(1);
                    OP_ORG_D: if (org_y < coord_t'(ORG_MAX)) org_y <= org_y + coord_t'(1);
                    OP_SCALE_D: begin
                        if (depth == D32) depth <= D16;
                        else if (depth == D16) depth <= D8;   // D8 is the floor
                    end
                    OP_SCALE_U: begin
                        if (depth == D8) depth <= D16;
                        else if (depth == D16) depth <= D32;
                    end
                    default: ;
                endcase
            end
        end
    end

    // -------------------------------------------------
    // outputs
    // -------------------------------------------------
    assign o_op_ready   = (state == S_READY);
    assign o_in_ready   = (state == S_LOAD);   // high for the whole load
    assign o_disp_start = (state == S_WAIT) && op_r.valid && (op_r.mode == OP_DISPLAY);

    assign wr_loc = raster_to_bank(load_cnt, BANK_COUNT);
    assign o_wr   = '{en:   (state == S_LOAD) && pix_r.valid,
                      bank: wr_loc.bank,
                      off:  wr_loc.off,
                      data: pix_r.data};

    assign o_win = '{x: org_x, y: org_y, depth: depth};

endmodule

`default_nettype wire

/* tb/img_tests.svh */
`ifndef IMG_TESTS_SVH
`define IMG_TESTS_SVH

// one row per test: ops run in order, then a DISPLAY closes the row
typedef struct packed {
    logic [3:0]      n_ops;   // used entries of ops
    logic [0:7][3:0] ops;
    logic [2:0]      x;       // expected origin after the ops
    logic [2:0]      y;
    logic [5:0]      ch;      // expected depth, in channels
} test_row_t;

localparam int         N_TESTS = 11;
localparam logic [3:0] NOP     = 4'd0;    // padding, never sent
localparam logic [3:0] OP_BAD  = 4'd12;   // undefined code

string test_names [N_TESTS] = '{"load_full", "shift_r_r_d", "shift_back", "undef_op",
                                "clamp_left_up", "clamp_right", "clamp_down",
                                "scale_down_1", "scale_down_2", "scale_up_3",
                                "scale_up_sat"};

test_row_t rows [N_TESTS] = '{
    '{4'd1, '{0: OP_LOAD, default: NOP}, 3'd0, 3'd0, 6'd32},
    '{4'd3, '{0: OP_ORG_R, 1: OP_ORG_R, 2: OP_ORG_D, default: NOP}, 3'd2, 3'd1, 6'd32},
    '{4'd3, '{0: OP_ORG_L, 1: OP_ORG_L, 2: OP_ORG_U, default: NOP}, 3'd0, 3'd0, 6'd32},
    '{4'd2, '{0: OP_BAD, 1: OP_ORG_R, default: NOP}, 3'd1, 3'd0, 6'd32},
    '{4'd3, '{0: OP_ORG_L, 1: OP_ORG_L, 2: OP_ORG_U, default: NOP}, 3'd0, 3'd0, 6'd32},
    '{4'd7, '{7: NOP, default: OP_ORG_R}, 3'd6, 3'd0, 6'd32},      // x saturates at 6
    '{4'd7, '{7: NOP, default: OP_ORG_D}, 3'd6, 3'd6, 6'd32},
    '{4'd1, '{0: OP_SCALE_D, default: NOP}, 3'd6, 3'd6, 6'd16},
    '{4'd1, '{0: OP_SCALE_D, default: NOP}, 3'd6, 3'd6, 6'd8},
    '{4'd3, '{0: OP_SCALE_U, 1: OP_SCALE_U, 2: OP_SCALE_U, default: NOP}, 3'd6, 3'd6, 6'd32},
    '{4'd1, '{0: OP_SCALE_U, default: NOP}, 3'd6, 3'd6, 6'd32}  // already at 32
};

`endif

/* tb/tb_img_core.sv */
`default_nettype none

module tb_img_core;
    timeunit 1ns;
    timeprecision 100ps;
    import img_pkg::*;

    `include "img_tests.svh"

    localparam int LIMIT = 2 * IMG_PIX + 200 * N_TESTS;   // cycles for the whole run

    logic     i_clk;
    logic     i_rst_n;
    op_cmd_t  i_op;
    pix_in_t  i_pix;
    logic     o_op_ready;
    logic     o_in_ready;
    pix_out_t o_pix;

    pixel_t      ref_img [IMG_PIX];   // raster order model of the image
    logic [31:0] rng;
    int          cycles;
    int          errors;
    int          row_err;
    int          passed;
    string       cur_name;

    img_core #(.BANK_COUNT(4)) i_img_core (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op       (i_op),
        .i_pix      (i_pix),
        .o_op_ready (o_op_ready),
        .o_in_ready (o_in_ready),
        .o_pix      (o_pix)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // x fastest, then y, then channel
    function automatic int ref_index(int x, int y, int c);
        return c * IMG_W * IMG_H + y * IMG_W + x;
    endfunction

    task automatic report_value(string what, int exp_v, int act_v);
        $display("Fail %s %s: expected %0d actual %0d", cur_name, what, exp_v, act_v);
        errors++;
        row_err++;
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #1;   // drive and sample just past the edge
    endtask

    task automatic send_op(logic [3:0] code);
        i_op.valid = 1'b1;
        i_op.mode  = op_mode_t'(code);
        next_cycle();
        i_op = '0;                     // one cycle only
    endtask

    // counts from the op cycle to the ready pulse
    task automatic check_turnaround(int exp_n);
        int n;
        n = 1;
        while (!o_op_ready && n < 8) begin
            next_cycle();
            n++;
        end
        if (n != exp_n) report_value("ready turnaround", exp_n, n);
    endtask

    task automatic load_image();
        int n;
        n = 0;
        while (!o_in_ready) next_cycle();
        while (n < IMG_PIX) begin
            if (!o_in_ready) report_value("in_ready during load", 1, 0);
            rng = xorshift(rng);
            if (rng[1:0] == 2'b00) begin
                i_pix = '0;                      // gap
            end else begin
                i_pix.valid = 1'b1;
                i_pix.data  = ref_img[n];
                n++;
            end
            next_cycle();
        end
        i_pix = '0;
        if (!o_in_ready) report_value("in_ready after last pixel", 1, 0);
        check_turnaround(2);
        if (o_in_ready) report_value("in_ready with op_ready", 0, 1);   // load is over
    endtask

    task automatic run_display(int r);
        int          exp_n;
        int          got;
        int          x;
        int          y;
        logic [13:0] exp_d;
        exp_n = 4 * int'(rows[r].ch);
        got   = 0;
        send_op(OP_DISPLAY);
        while (!o_op_ready) begin
            if (o_pix.valid) begin
                if (got < exp_n) begin
                    x     = int'(rows[r].x) + (got % 4) % 2;
                    y     = int'(rows[r].y) + (got % 4) / 2;
                    exp_d = {6'd0, ref_img[ref_index(x, y, got / 4)]};
                    if (o_pix.data !== exp_d) report_value("pixel", int'(exp_d), int'(o_pix.data));
                end
                got++;
            end else if (got > 0 && got < exp_n) begin
                report_value("output valid in stream", 1, 0);   // outputs come back to back
            end
            next_cycle();
        end
        if (got != exp_n) report_value("display count", exp_n, got);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        logic [3:0] op;
        logic       skip_ready;
        i_clk   = 1'b0;
        i_rst_n = 1'b0;
        i_op    = '0;
        i_pix   = '0;
        rng     = 32'd64;
        cycles  = 0;
        errors  = 0;
        passed  = 0;
        for (int i = 0; i < IMG_PIX; i++) begin
            rng        = xorshift(rng);
            ref_img[i] = rng[15:8];
        end
        repeat (8) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        for (int r = 0; r < N_TESTS; r++) begin
            row_err    = 0;
            cur_name   = test_names[r];
            skip_ready = 1'b0;
            for (int k = 0; k < int'(rows[r].n_ops); k++) begin
                op = rows[r].ops[k];
                if (!skip_ready) begin
                    while (!o_op_ready) next_cycle();
                end
                skip_ready = 1'b0;
                send_op(op);
                if (op == OP_LOAD) begin
                    load_image();
                end else if (op > 4'd7) begin
                    for (int w = 0; w < 20; w++) begin   // must stay quiet
                        if (o_op_ready) report_value("ready after undefined op", 0, 1);
                        next_cycle();
                    end
                    skip_ready = 1'b1;
                end else begin
                    check_turnaround(3);
                end
            end
            while (!o_op_ready) next_cycle();
            run_display(r);
            if (row_err == 0) passed++;
            $display("test %0d %s: %s (%0d errors)", r, cur_name,
                     (row_err == 0) ? "ok" : "wrong", row_err);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 N_TESTS, passed, N_TESTS - passed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
